// File: list.f
source/mrd_pkg.sv
source/mrd_div7.sv
source/mrd_bank_ram.sv
source/mrd_group_addr_gen.sv
source/mrd_butterfly.sv
source/mrd_ctrl.sv
source/mrd_mem_top.sv
source/mrd_dft_top.sv
verif/mrd_clk_gen.sv
verif/mrd_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module mrd_tb -o mrd_sim &&
./obj_dir/mrd_sim || { echo "Simulation run failed"; exit 1; }

// File: verif/mrd_tb.sv
module mrd_tb
	import mrd_pkg::*;
();

	localparam int N_FRAMES = 5;
	localparam int FRAME_PTS  [N_FRAMES] = '{16, 64, 20, 40, 48};
	localparam int FRAME_RDX  [N_FRAMES] = '{2, 4, 4, 2, 4};
	localparam bit FRAME_FULL [N_FRAMES] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid, in_sop, in_eop;
	logic signed [IN_W-1:0] in_real, in_imag;
	logic [PTS_W-1:0]       cfg_pts;
	radix_e                 cfg_radix;
	logic                   out_valid_o, out_sop_o, out_eop_o, busy_o;
	cplx_t                  out_data_o;

	logic [31:0] lfsr_state = 32'h787cd027;
	int          in_re_arr [MAX_PTS];
	int          in_im_arr [MAX_PTS];
	cplx_t       exp_frame [MAX_PTS];
	int          exp_n = 0;
	string       test_name = "reset";
	int          out_cnt = 0;
	int          frames_done = 0;
	logic        busy_exp = 1'b0;
	int          cycle_cnt = 0;
	int          cycle_limit;

	mrd_clk_gen u_clk (.clk_o(clk));

	mrd_dft_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (in_valid),
		.in_sop_i    (in_sop),
		.in_eop_i    (in_eop),
		.in_real_i   (in_real),
		.in_imag_i   (in_imag),
		.cfg_pts_i   (cfg_pts),
		.cfg_radix_i (cfg_radix),
		.out_valid_o (out_valid_o),
		.out_sop_o   (out_sop_o),
		.out_eop_o   (out_eop_o),
		.out_data_o  (out_data_o),
		.busy_o      (busy_o)
	);

	// ----------------------------------------------------------
	// Random source and reference model
	// ----------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
	endfunction

	function automatic logic [IN_W-1:0] draw_word();
		logic [IN_W-1:0] w;
		w = '0;
		for (int b = 0; b < IN_W; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[IN_W-2:0], lfsr_state[0]};   // One step per bit
		end
		return w;
	endfunction

	// Direct R-point DFT per group with W4 powers as quarter turns
	function automatic void ref_stage(input int in_re[MAX_PTS], input int in_im[MAX_PTS],
		input int n, input radix_e rdx, output cplx_t res[MAX_PTS]);
		int r_pts, m, p, xr, xi, acc_re, acc_im;
		r_pts = (rdx == RDX4) ? 4 : 2;
		m = n / r_pts;
		for (int g = 0; g < m; g++)
		begin
			for (int k = 0; k < r_pts; k++)
			begin
				acc_re = 0;
				acc_im = 0;
				for (int r = 0; r < r_pts; r++)
				begin
					xr = in_re[g + r * m];
					xi = in_im[g + r * m];
					p  = (r * k * (4 / r_pts)) % 4;   // Power of -j
					case (p)
						0:
						begin
							acc_re += xr;
							acc_im += xi;
						end
						1:
						begin
							acc_re += xi;
							acc_im -= xr;
						end
						2:
						begin
							acc_re -= xr;
							acc_im -= xi;
						end
						default:
						begin
							acc_re -= xi;
							acc_im += xr;
						end
					endcase
				end
				res[g + k * m].re = DW'(acc_re);
				res[g + k * m].im = DW'(acc_im);
			end
		end
	endfunction

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_cplx(input string name, input cplx_t exp, input cplx_t act);
		if (act !== exp)
		begin
			$display("ERR %s expected (%0d, %0d) actual (%0d, %0d)",
				name, exp.re, exp.im, act.re, act.im);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	// Outputs sampled mid-cycle away from the clock edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			check_bit({test_name, " busy_o"}, busy_exp, busy_o);
			if (out_valid_o)
			begin
				if (out_cnt >= exp_n)
				begin
					$display("out_valid_o stayed high past the end of frame %s", test_name);
					stop_on_failure();
				end
				check_bit({test_name, " out_sop_o"}, out_cnt == 0, out_sop_o);
				check_bit({test_name, " out_eop_o"}, out_cnt == exp_n - 1, out_eop_o);
				check_cplx($sformatf("%s sample %0d", test_name, out_cnt),
					exp_frame[out_cnt], out_data_o);
				out_cnt++;
				if (out_eop_o)
				begin
					out_cnt = 0;
					frames_done++;
				end
			end
			else
			begin
				if (out_cnt != 0)
				begin
					$display("out_valid_o dropped in the middle of frame %s", test_name);
					stop_on_failure();
				end
				check_bit({test_name, " idle out_sop_o"}, 1'b0, out_sop_o);
				check_bit({test_name, " idle out_eop_o"}, 1'b0, out_eop_o);
			end
			if (in_valid && in_eop)
				busy_exp = 1'b1;   // High from the next cycle
			if (out_valid_o && out_eop_o)
				busy_exp = 1'b0;
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("Run timed out after %0d cycles", cycle_cnt);
			stop_on_failure();
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	task automatic send_frame(input int f);
		int     n;
		radix_e rdx;
		n   = FRAME_PTS[f];
		rdx = (FRAME_RDX[f] == 4) ? RDX4 : RDX2;
		for (int i = 0; i < n; i++)
		begin
			if (FRAME_FULL[f])
			begin
				in_re_arr[i] = 32767;
				in_im_arr[i] = -32767;
			end
			else
			begin
				in_re_arr[i] = int'($signed(draw_word()));
				in_im_arr[i] = int'($signed(draw_word()));
			end
		end
		ref_stage(in_re_arr, in_im_arr, n, rdx, exp_frame);
		exp_n     = n;
		test_name = $sformatf("r%0d_n%0d%s", FRAME_RDX[f], n, FRAME_FULL[f] ? "_full" : "");
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#2;
			in_valid  = 1'b1;
			in_sop    = (i == 0);
			in_eop    = (i == n - 1);
			in_real   = IN_W'(in_re_arr[i]);
			in_imag   = IN_W'(in_im_arr[i]);
			// Configuration is only meaningful alongside sop
			cfg_pts   = (i == 0) ? PTS_W'(n) : '0;
			cfg_radix = (i == 0) ? rdx : ((rdx == RDX4) ? RDX2 : RDX4);
		end
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		in_sop   = 1'b0;
		in_eop   = 1'b0;
		wait (frames_done == f + 1);
		while (busy_o)
			@(negedge clk);
	endtask

	initial
	begin
		cycle_limit = 0;
		for (int f = 0; f < N_FRAMES; f++)
			cycle_limit += 4 * FRAME_PTS[f] + 40;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_sop    = 1'b0;
		in_eop    = 1'b0;
		in_real   = '0;
		in_imag   = '0;
		cfg_pts   = '0;
		cfg_radix = RDX2;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("reset out_valid_o", 1'b0, out_valid_o);
		check_bit("reset busy_o", 1'b0, busy_o);

		for (int f = 0; f < N_FRAMES; f++)
			send_frame(f);

		$display("All tests passed");
		$finish;
	end

endmodule

// File: verif/mrd_clk_gen.sv
module mrd_clk_gen
(
	output logic clk_o
);

	// Period of 20, first rising edge at 10
	initial
	begin
		clk_o = 1'b0;
		forever
			#10 clk_o = ~clk_o;
	end

endmodule

// File: source/mrd_dft_top.sv
module mrd_dft_top
	import mrd_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid_i,
	input  logic                   in_sop_i,
	input  logic                   in_eop_i,
	input  logic signed [IN_W-1:0] in_real_i,
	input  logic signed [IN_W-1:0] in_imag_i,
	input  logic [PTS_W-1:0]       cfg_pts_i,
	input  radix_e                 cfg_radix_i,
	output logic                   out_valid_o,
	output logic                   out_sop_o,
	output logic                   out_eop_o,
	output cplx_t                  out_data_o,
	output logic                   busy_o
);

	ctrl_state_e      state;
	logic [PTS_W-1:0] pts;
	radix_e           radix;
	logic             grp_start, grp_done, src_start, src_done;
	grp_t             rd_req, rd_grp, bf_grp;

	mrd_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_sop_i    (in_sop_i),
		.in_eop_i    (in_eop_i),
		.cfg_pts_i   (cfg_pts_i),
		.cfg_radix_i (cfg_radix_i),
		.grp_done_i  (grp_done),
		.src_done_i  (src_done),
		.state_o     (state),
		.pts_o       (pts),
		.radix_o     (radix),
		.grp_start_o (grp_start),
		.src_start_o (src_start),
		.busy_o      (busy_o)
	);

	mrd_group_addr_gen u_addr_gen (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (grp_start),
		.pts_i   (pts),
		.radix_i (radix),
		.req_o   (rd_req),
		.done_o  (grp_done)
	);

	mrd_mem_top u_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.state_i     (state),
		.pts_i       (pts),
		.radix_i     (radix),
		.in_valid_i  (in_valid_i),
		.in_sop_i    (in_sop_i),
		.in_real_i   (in_real_i),
		.in_imag_i   (in_imag_i),
		.rd_req_i    (rd_req),
		.wb_i        (bf_grp),
		.src_start_i (src_start),
		.rd_grp_o    (rd_grp),
		.out_valid_o (out_valid_o),
		.out_sop_o   (out_sop_o),
		.out_eop_o   (out_eop_o),
		.out_data_o  (out_data_o),
		.src_done_o  (src_done)
	);

	mrd_butterfly u_bfly (
		.clk     (clk),
		.rst_n   (rst_n),
		.radix_i (radix),
		.grp_i   (rd_grp),
		.grp_o   (bf_grp)
	);

endmodule

// File: source/mrd_mem_top.sv
module mrd_mem_top
	import mrd_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  ctrl_state_e            state_i,
	input  logic [PTS_W-1:0]       pts_i,
	input  radix_e                 radix_i,
	input  logic                   in_valid_i,
	input  logic                   in_sop_i,
	input  logic signed [IN_W-1:0] in_real_i,
	input  logic signed [IN_W-1:0] in_imag_i,
	input  grp_t                   rd_req_i,
	input  grp_t                   wb_i,
	input  logic                   src_start_i,
	output grp_t                   rd_grp_o,
	output logic                   out_valid_o,
	output logic                   out_sop_o,
	output logic                   out_eop_o,
	output cplx_t                  out_data_o,
	output logic                   src_done_o
);

	logic [N_BANKS-1:0]              bank_we, bank_re;
	logic [N_BANKS-1:0][BANK_AW-1:0] bank_waddr, bank_raddr;
	cplx_t [N_BANKS-1:0]             bank_wdata, bank_rdata;

	logic [PTS_W-1:0]                snk_cnt, snk_idx;
	logic [BANK_AW-1:0]              snk_addr, snk_addr_r;
	logic [2:0]                      snk_bank, snk_bank_r;
	logic                            snk_we_r;
	cplx_t                           snk_data_r;

	logic [MAX_RDX-1:0]              lane_en;
	logic [MAX_RDX-1:0][BANK_AW-1:0] rd_addr, wb_addr;
	logic [MAX_RDX-1:0][2:0]         rd_bank, wb_bank, rd_bank_r;
	logic [MAX_RDX-1:0][PTS_W-1:0]   rd_idx_r;
	logic                            rd_valid_r, rd_conflict;
	logic [N_BANKS-1:0]              rd_re, wb_we;
	logic [N_BANKS-1:0][BANK_AW-1:0] rd_raddr, wb_waddr;
	cplx_t [N_BANKS-1:0]             wb_wdata;

	logic                            src_active;
	logic [PTS_W-1:0]                src_cnt;
	logic [BANK_AW-1:0]              src_addr;
	logic [2:0]                      src_bank, src_bank_r;

	for (genvar k = 0; k < N_BANKS; k++)
	begin : g_bank
		mrd_bank_ram u_bank (
			.clk     (clk),
			.we_i    (bank_we[k]),
			.waddr_i (bank_waddr[k]),
			.wdata_i (bank_wdata[k]),
			.re_i    (bank_re[k]),
			.raddr_i (bank_raddr[k]),
			.rdata_o (bank_rdata[k])
		);
	end

	// ----------------------------------------------------------
	// Sink
	// ----------------------------------------------------------
	assign snk_idx = in_sop_i ? '0 : snk_cnt;

	mrd_div7 u_div_snk (.dividend_i(snk_idx), .bank_addr_o(snk_addr), .bank_idx_o(snk_bank));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			snk_cnt  <= '0;
			snk_we_r <= 1'b0;
		end
		else
		begin
			snk_we_r <= in_valid_i && (state_i == ST_SINK);
			if (in_valid_i && (state_i == ST_SINK))
				snk_cnt <= snk_idx + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		snk_addr_r    <= snk_addr;
		snk_bank_r    <= snk_bank;
		snk_data_r.re <= {{(DW-IN_W){in_real_i[IN_W-1]}}, in_real_i};
		snk_data_r.im <= {{(DW-IN_W){in_imag_i[IN_W-1]}}, in_imag_i};
	end

	// ----------------------------------------------------------
	// Compute: lane to bank crossbars
	// ----------------------------------------------------------
	for (genvar r = 0; r < MAX_RDX; r++)
	begin : g_lane
		assign lane_en[r] = (r < 2) || (radix_i == RDX4);
		mrd_div7 u_div_rd (.dividend_i(rd_req_i.idx[r]), .bank_addr_o(rd_addr[r]),
			.bank_idx_o(rd_bank[r]));
		mrd_div7 u_div_wb (.dividend_i(wb_i.idx[r]), .bank_addr_o(wb_addr[r]),
			.bank_idx_o(wb_bank[r]));
	end

	always_comb
	begin
		rd_re    = '0;
		rd_raddr = '0;
		wb_we    = '0;
		wb_waddr = '0;
		wb_wdata = '0;
		for (int k = 0; k < N_BANKS; k++)
		begin
			for (int r = 0; r < MAX_RDX; r++)
			begin
				if (rd_req_i.valid && lane_en[r] && rd_bank[r] == 3'(k))
				begin
					rd_re[k]    = 1'b1;
					rd_raddr[k] = rd_addr[r];
				end
				if (wb_i.valid && lane_en[r] && wb_bank[r] == 3'(k))
				begin
					wb_we[k]    = 1'b1;
					wb_waddr[k] = wb_addr[r];
					wb_wdata[k] = wb_i.data[r];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_valid_r <= 1'b0;
		else
			rd_valid_r <= rd_req_i.valid;
	end

	always_ff @(posedge clk)
	begin
		rd_idx_r  <= rd_req_i.idx;
		rd_bank_r <= rd_bank;   // Lines up with the RAM read latency
	end

	// Bank outputs back into lane order
	always_comb
	begin
		rd_grp_o.valid = rd_valid_r;
		rd_grp_o.idx   = rd_idx_r;
		for (int r = 0; r < MAX_RDX; r++)
			rd_grp_o.data[r] = bank_rdata[rd_bank_r[r]];
	end

	// Sink and write-back never overlap in time
	always_comb
	begin
		for (int k = 0; k < N_BANKS; k++)
		begin
			bank_we[k]    = snk_we_r ? (snk_bank_r == 3'(k)) : wb_we[k];
			bank_waddr[k] = snk_we_r ? snk_addr_r : wb_waddr[k];
			bank_wdata[k] = snk_we_r ? snk_data_r : wb_wdata[k];
			bank_re[k]    = src_active ? (src_bank == 3'(k)) : rd_re[k];
			bank_raddr[k] = src_active ? src_addr : rd_raddr[k];
		end
	end

	always_comb
	begin
		rd_conflict = 1'b0;
		for (int a = 0; a < MAX_RDX; a++)
			for (int b = a + 1; b < MAX_RDX; b++)
				if (lane_en[a] && lane_en[b] && rd_bank[a] == rd_bank[b])
					rd_conflict = 1'b1;
	end

	a_lane_banks: assert property (@(posedge clk) disable iff (!rst_n)
		rd_req_i.valid |-> !rd_conflict);

	// ----------------------------------------------------------
	// Source
	// ----------------------------------------------------------
	assign src_done_o = src_active && (src_cnt == pts_i - 1'b1);

	mrd_div7 u_div_src (.dividend_i(src_cnt), .bank_addr_o(src_addr), .bank_idx_o(src_bank));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			src_active  <= 1'b0;
			src_cnt     <= '0;
			out_valid_o <= 1'b0;
			out_sop_o   <= 1'b0;
			out_eop_o   <= 1'b0;
		end
		else
		begin
			out_valid_o <= src_active;
			out_sop_o   <= src_active && (src_cnt == '0);
			out_eop_o   <= src_done_o;
			if (src_start_i)
			begin
				src_active <= 1'b1;
				src_cnt    <= '0;
			end
			else if (src_done_o)
				src_active <= 1'b0;
			else if (src_active)
				src_cnt <= src_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		src_bank_r <= src_bank;
	end

	assign out_data_o = bank_rdata[src_bank_r];

endmodule

// File: source/mrd_ctrl.sv
module mrd_ctrl
	import mrd_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_sop_i,
	input  logic             in_eop_i,
	input  logic [PTS_W-1:0] cfg_pts_i,
	input  radix_e           cfg_radix_i,
	input  logic             grp_done_i,
	input  logic             src_done_i,
	output ctrl_state_e      state_o,
	output logic [PTS_W-1:0] pts_o,
	output radix_e           radix_o,
	output logic             grp_start_o,
	output logic             src_start_o,
	output logic             busy_o
);

	logic [1:0]       drain_cnt;
	logic             src_last_r;
	logic [PTS_W-1:0] stride;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_o     <= ST_SINK;
			drain_cnt   <= '0;
			src_last_r  <= 1'b0;
			grp_start_o <= 1'b0;
			src_start_o <= 1'b0;
			pts_o       <= '0;
			radix_o     <= RDX2;
		end
		else
		begin
			grp_start_o <= 1'b0;
			src_start_o <= 1'b0;
			src_last_r  <= src_done_i;   // Last read leaves the banks next cycle
			case (state_o)
				ST_SINK:
				begin
					if (in_sop_i)
					begin
						pts_o   <= cfg_pts_i;
						radix_o <= cfg_radix_i;
					end
					if (in_eop_i)
					begin
						state_o     <= ST_COMPUTE;
						grp_start_o <= 1'b1;
					end
				end
				ST_COMPUTE:
				begin
					if (grp_done_i)
					begin
						state_o   <= ST_DRAIN;
						drain_cnt <= '0;
					end
				end
				// Three cycles for the last group to reach the banks
				ST_DRAIN:
				begin
					if (drain_cnt == 2'd2)
					begin
						state_o     <= ST_SOURCE;
						src_start_o <= 1'b1;
					end
					else
						drain_cnt <= drain_cnt + 1'b1;
				end
				ST_SOURCE:
				begin
					if (src_last_r)
						state_o <= ST_SINK;
				end
				default: state_o <= ST_SINK;
			endcase
		end
	end

	assign busy_o = (state_o != ST_SINK);
	assign stride = (radix_o == RDX4) ? (pts_o >> 2) : (pts_o >> 1);

	a_sop_in_sink: assert property (@(posedge clk) disable iff (!rst_n)
		in_sop_i |-> state_o == ST_SINK);

	// A stride of 7k would put two lanes in one bank
	a_stride_ok: assert property (@(posedge clk) disable iff (!rst_n)
		state_o == ST_COMPUTE |-> (stride % 7 != 0) && (pts_o <= MAX_PTS));

endmodule

// File: source/mrd_butterfly.sv
module mrd_butterfly
	import mrd_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  radix_e radix_i,
	input  grp_t   grp_i,
	output grp_t   grp_o
);

	cplx_t                         x0, x1, x2, x3;
	cplx_t                         a, b, c, d;
	cplx_t [MAX_RDX-1:0]           y;
	logic                          valid_r;
	logic [MAX_RDX-1:0][PTS_W-1:0] idx_r;
	cplx_t [MAX_RDX-1:0]           data_r;

	function automatic cplx_t c_add(cplx_t p, cplx_t q);
		cplx_t s;
		s.re = p.re + q.re;
		s.im = p.im + q.im;
		return s;
	endfunction

	function automatic cplx_t c_sub(cplx_t p, cplx_t q);
		cplx_t s;
		s.re = p.re - q.re;
		s.im = p.im - q.im;
		return s;
	endfunction

	always_comb
	begin
		x0 = grp_i.data[0];
		x1 = grp_i.data[1];
		x2 = grp_i.data[2];
		x3 = grp_i.data[3];
		a  = c_add(x0, x2);
		b  = c_sub(x0, x2);
		c  = c_add(x1, x3);
		d  = c_sub(x1, x3);
		if (radix_i == RDX4)
		begin
			y[0]    = c_add(a, c);
			y[2]    = c_sub(a, c);
			y[1].re = b.re + d.im;   // b - j*d
			y[1].im = b.im - d.re;
			y[3].re = b.re - d.im;   // b + j*d
			y[3].im = b.im + d.re;
		end
		else
		begin
			y[0] = c_add(x0, x1);
			y[1] = c_sub(x0, x1);
			y[2] = x2;   // Unused lanes pass through
			y[3] = x3;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_r <= 1'b0;
		else
			valid_r <= grp_i.valid;
	end

	// Indices ride along so the write-back lands where the read came from
	always_ff @(posedge clk)
	begin
		idx_r  <= grp_i.idx;
		data_r <= y;
	end

	assign grp_o = '{valid: valid_r, idx: idx_r, data: data_r};

endmodule

// File: source/mrd_group_addr_gen.sv
module mrd_group_addr_gen
	import mrd_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start_i,
	input  logic [PTS_W-1:0] pts_i,
	input  radix_e           radix_i,
	output grp_t             req_o,
	output logic             done_o
);

	logic [PTS_W-1:0] grp_cnt;
	logic [PTS_W-1:0] stride;
	logic             active;

	assign stride = (radix_i == RDX4) ? (pts_i >> 2) : (pts_i >> 1);   // M = N / R

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active  <= 1'b0;
			grp_cnt <= '0;
			done_o  <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			if (start_i)
			begin
				active  <= 1'b1;
				grp_cnt <= '0;
			end
			else if (active)
			begin
				if (grp_cnt == stride - 1'b1)
				begin
					active <= 1'b0;
					done_o <= 1'b1;   // One cycle after the last group
				end
				else
					grp_cnt <= grp_cnt + 1'b1;
			end
		end
	end

	// Lane r reads sample g + r*M
	always_comb
	begin
		req_o.valid = active;
		req_o.data  = '0;
		for (int r = 0; r < MAX_RDX; r++)
			req_o.idx[r] = grp_cnt + PTS_W'(r) * stride;
	end

	// Highest active lane of every group stays inside the frame
	a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
		req_o.valid |-> (req_o.idx[1] < pts_i) && (radix_i == RDX2 || req_o.idx[3] < pts_i));

endmodule

// File: source/mrd_bank_ram.sv
module mrd_bank_ram
	import mrd_pkg::*;
(
	input  logic               clk,
	input  logic               we_i,
	input  logic [BANK_AW-1:0] waddr_i,
	input  cplx_t              wdata_i,
	input  logic               re_i,
	input  logic [BANK_AW-1:0] raddr_i,
	output cplx_t              rdata_o
);

	cplx_t mem [2**BANK_AW];

	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// Read data holds when the bank is idle
	always_ff @(posedge clk)
	begin
		if (re_i)
			rdata_o <= mem[raddr_i];
	end

endmodule

// File: source/mrd_div7.sv
module mrd_div7
	import mrd_pkg::*;
(
	input  logic [PTS_W-1:0]   dividend_i,
	output logic [BANK_AW-1:0] bank_addr_o,
	output logic [2:0]         bank_idx_o
);

	logic [17:0]      prod;
	logic [6:0]       quot;
	logic [PTS_W-1:0] rem_full;

	// 293/2048 approximates 1/7, exact for dividends below 682
	assign prod = 18'(dividend_i) * 18'd293;
	assign quot = prod[17:11];

	assign rem_full = dividend_i - PTS_W'(quot * 10'd7);

	assign bank_addr_o = quot[BANK_AW-1:0];
	assign bank_idx_o  = rem_full[2:0];   // Always 0..6

endmodule

// File: source/mrd_pkg.sv
package mrd_pkg;

	// ----------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------
	localparam int N_BANKS = 7;
	localparam int BANK_AW = 6;     // 37 words needed for 256 points
	localparam int MAX_PTS = 256;
	localparam int PTS_W   = 9;
	localparam int IN_W    = 16;
	localparam int DW      = 18;    // Two bits of radix-4 growth
	localparam int MAX_RDX = 4;

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------
	typedef struct packed
	{
		logic signed [DW-1:0] re;
		logic signed [DW-1:0] im;
	} cplx_t;

	typedef enum logic
	{
		RDX2,
		RDX4
	} radix_e;

	typedef enum logic [1:0]
	{
		ST_SINK,
		ST_COMPUTE,
		ST_DRAIN,
		ST_SOURCE
	} ctrl_state_e;

	// One butterfly group, lanes at or above the radix are don't-care
	typedef struct packed
	{
		logic                          valid;
		logic [MAX_RDX-1:0][PTS_W-1:0] idx;
		cplx_t [MAX_RDX-1:0]           data;
	} grp_t;

endpackage
